// File: Makefile
# Verilator build and run of the BDCR slice testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_rcc_vsw \
		-f verilog.f -o tb_rcc_vsw
	-./obj_dir/tb_rcc_vsw | tee $(LOG)
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: src/rcc_apb_slave.sv
// ------------------------------
// apb4 slave for bdcr
// no wait states, pready not present
// any offset other than BDCR_ADDR gives pslverr
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module rcc_apb_slave (
  input  wire                           clk,
  input  wire                           rst,
  // apb4 request
  input  wire  [rcc_pkg::ADDR_W-1:0]    paddr,
  input  wire                           psel,
  input  wire                           penable,
  input  wire                           pwrite,
  input  wire  [rcc_pkg::DATA_W-1:0]    pwdata,
  input  wire  [rcc_pkg::DATA_W/8-1:0]  pstrb,
  // apb4 response
  output logic [rcc_pkg::DATA_W-1:0]    prdata,
  output logic                          pslverr,
  // byte write enables
  output logic                          byte2_wren,
  output logic                          byte1_wren,
  output logic                          byte0_wren,
  // next field values
  output logic                          nxt_bdrst,
  output logic                          nxt_rtcen,
  output rcc_pkg::rtc_src_e             nxt_rtcsel,
  output logic                          nxt_lsecsson,
  output logic [1:0]                    nxt_lsedrv,
  output logic                          nxt_lsebyp,
  output logic                          nxt_lseon,
  // register read-back
  input  wire  [rcc_pkg::DATA_W-1:0]    cur_bdcr
);

  logic access;
  logic addr_hit;
  logic wr_hit;
  logic rd_hit;

  // ------------------------------
  // phase and address decode
  // ------------------------------
  // access phase, always completes here
  assign access   = psel & penable;
  assign addr_hit = (paddr == rcc_pkg::BDCR_ADDR);
  assign wr_hit   = access & pwrite & addr_hit;
  assign rd_hit   = access & ~pwrite & addr_hit;

  // unmapped offset flagged in access phase only
  assign pslverr = access & ~addr_hit;

  // ------------------------------
  // write path
  // ------------------------------
  // one enable per populated byte
  assign byte2_wren = wr_hit & pstrb[2];
  assign byte1_wren = wr_hit & pstrb[1];
  assign byte0_wren = wr_hit & pstrb[0];

  // field slices of pwdata
  // lsecssd and lserdy are read-only, not forwarded
  assign nxt_bdrst    = pwdata[rcc_pkg::BIT_BDRST];
  assign nxt_rtcen    = pwdata[rcc_pkg::BIT_RTCEN];
  assign nxt_rtcsel   = rcc_pkg::rtc_src_e'(pwdata[rcc_pkg::LSB_RTCSEL +: 2]);
  assign nxt_lsecsson = pwdata[rcc_pkg::BIT_LSECSSON];
  assign nxt_lsedrv   = pwdata[rcc_pkg::LSB_LSEDRV +: 2];
  assign nxt_lsebyp   = pwdata[rcc_pkg::BIT_LSEBYP];
  assign nxt_lseon    = pwdata[rcc_pkg::BIT_LSEON];

  // ------------------------------
  // read path
  // ------------------------------
  // combinational, zero outside a mapped read
  assign prdata = rd_hit ? cur_bdcr : '0;

  // ------------------------------
  // protocol check
  // ------------------------------
  // access phase must follow a setup cycle
  a_setup_before_access: assert property (
    @(posedge clk) disable iff (rst)
    $rose(penable) |-> (psel && $past(psel))
  ) else $error("penable rose without a preceding setup cycle");

endmodule

`default_nettype wire

// File: src/rcc_lse_ctrl.sv
// ------------------------------
// lse oscillator model and rtc tick select
// ticks are one-cycle enables on clk
// after a css failure lse stays dead until lseon drops
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module rcc_lse_ctrl #(
  parameter int LSE_STARTUP = 8,
  parameter int CSS_TIMEOUT = 32,
  parameter int HSE_DIV     = 4
) (
  input  wire                   clk,
  input  wire                   rst,
  // register fields
  input  wire                   lseon,
  input  wire                   lsebyp,
  input  wire                   lsecsson,
  input  wire                   rtcen,
  input  var rcc_pkg::rtc_src_e rtcsel,
  // source ticks
  input  wire                   lse_tick,
  input  wire                   lsi_tick,
  input  wire                   hse_tick,
  // status and kernel tick
  output logic                  lserdy,
  output logic                  lsecss_fail,
  output logic                  rtc_tick
);

  localparam int START_W = $clog2(LSE_STARTUP + 1);
  localparam int MISS_W  = $clog2(CSS_TIMEOUT + 1);
  localparam int DIV_W   = $clog2(HSE_DIV + 1);

  logic [START_W-1:0] start_cnt;
  logic [START_W-1:0] start_last;
  logic               lse_failed;
  logic [MISS_W-1:0]  miss_cnt;
  logic               css_watch;
  logic               css_expire;
  logic [DIV_W-1:0]   hse_cnt;
  logic               hse_div_tick;
  logic               lse_src_tick;
  logic               sel_tick;

  // ------------------------------
  // startup counter
  // ------------------------------
  // bypass needs a single tick
  assign start_last = lsebyp ? '0 : START_W'(LSE_STARTUP - 1);

  always_ff @(posedge clk) begin
    if (rst || !lseon || css_expire) begin
      start_cnt <= '0;
      lserdy    <= 1'b0;
    end else if (lse_tick && !lserdy && !lse_failed) begin
      // ready on the last startup tick
      if (start_cnt >= start_last) begin
        lserdy <= 1'b1;
      end else begin
        start_cnt <= start_cnt + 1'b1;
      end
    end
  end

  // failed oscillator, released by lseon low
  always_ff @(posedge clk) begin
    if (rst || !lseon) begin
      lse_failed <= 1'b0;
    end else if (css_expire) begin
      lse_failed <= 1'b1;
    end
  end

  // ------------------------------
  // clock security
  // ------------------------------
  // watch only a running, monitored oscillator
  assign css_watch  = lsecsson & lserdy;
  assign css_expire = css_watch & ~lse_tick & (miss_cnt == MISS_W'(CSS_TIMEOUT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      miss_cnt    <= '0;
      lsecss_fail <= 1'b0;
    end else begin
      lsecss_fail <= css_expire;
      if (!css_watch || lse_tick || css_expire) begin
        miss_cnt <= '0;
      end else begin
        miss_cnt <= miss_cnt + 1'b1;
      end
    end
  end

  // ------------------------------
  // rtc tick
  // ------------------------------
  // hse divider restarts when hse is not the active source
  assign hse_div_tick = hse_tick & (hse_cnt == DIV_W'(HSE_DIV - 1));

  always_ff @(posedge clk) begin
    if (rst || !rtcen || rtcsel != rcc_pkg::RTC_HSE) begin
      hse_cnt <= '0;
    end else if (hse_tick) begin
      hse_cnt <= hse_div_tick ? '0 : hse_cnt + 1'b1;
    end
  end

  // lse ticks dropped once the oscillator is declared lost
  assign lse_src_tick = lse_tick & lseon & ~lse_failed;

  always_comb begin
    case (rtcsel)
      rcc_pkg::RTC_LSE: sel_tick = lse_src_tick;
      rcc_pkg::RTC_LSI: sel_tick = lsi_tick;
      rcc_pkg::RTC_HSE: sel_tick = hse_div_tick;
      default:          sel_tick = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rtc_tick <= 1'b0;
    end else begin
      rtc_tick <= rtcen & sel_tick;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  a_css_single_pulse: assert property (
    @(posedge clk) disable iff (rst)
    lsecss_fail |=> !lsecss_fail
  ) else $error("lsecss_fail held for more than one cycle");

endmodule

`default_nettype wire

// File: src/rcc_pkg.sv
// ------------------------------
// shared definitions for the bdcr slice
// only one register is mapped at BDCR_ADDR
// field positions follow the rcc bdcr layout
// ------------------------------
`default_nettype none

package rcc_pkg;

  // ------------------------------
  // apb bus geometry
  // ------------------------------
  parameter int ADDR_W = 12;
  parameter int DATA_W = 32;

  // byte offset of bdcr
  parameter logic [ADDR_W-1:0] BDCR_ADDR = 12'h000;

  // ------------------------------
  // bdcr field positions
  // ------------------------------
  // byte 2
  parameter int BIT_BDRST    = 16;
  // byte 1
  parameter int BIT_RTCEN    = 15;
  parameter int LSB_RTCSEL   = 8;
  // byte 0
  parameter int BIT_LSECSSD  = 6;
  parameter int BIT_LSECSSON = 5;
  parameter int LSB_LSEDRV   = 3;
  parameter int BIT_LSEBYP   = 2;
  parameter int BIT_LSERDY   = 1;
  parameter int BIT_LSEON    = 0;

  // whole register after reset
  parameter logic [DATA_W-1:0] BDCR_RST = 32'h0000_0000;

  // ------------------------------
  // rtc kernel clock source
  // ------------------------------
  // encoding matches rtcsel[1:0]
  typedef enum logic [1:0] {
    RTC_NONE = 2'b00,
    RTC_LSE  = 2'b01,
    RTC_LSI  = 2'b10,
    RTC_HSE  = 2'b11
  } rtc_src_e;

endpackage

`default_nettype wire

// File: src/rcc_vsw_reg.sv
// ------------------------------
// bdcr register bank on clk
// bdrst holds all other fields at reset value
// rtcsel reopens only after lsecss_fail
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module rcc_vsw_reg (
  input  wire                         clk,
  input  wire                         rst,
  // byte write enables
  input  wire                         byte2_wren,
  input  wire                         byte1_wren,
  input  wire                         byte0_wren,
  // next field values
  input  wire                         nxt_bdrst,
  input  wire                         nxt_rtcen,
  input  var rcc_pkg::rtc_src_e       nxt_rtcsel,
  input  wire                         nxt_lsecsson,
  input  wire  [1:0]                  nxt_lsedrv,
  input  wire                         nxt_lsebyp,
  input  wire                         nxt_lseon,
  // status from oscillator control
  input  wire                         lsecss_fail,
  input  wire                         lserdy,
  // field outputs
  output logic                        bdrst,
  output logic                        rtcen,
  output rcc_pkg::rtc_src_e           rtcsel,
  output logic                        lsecssd,
  output logic                        lsecsson,
  output logic [1:0]                  lsedrv,
  output logic                        lsebyp,
  output logic                        lseon,
  // read-back word
  output logic [rcc_pkg::DATA_W-1:0]  cur_bdcr
);

  localparam logic [rcc_pkg::DATA_W-1:0] RV = rcc_pkg::BDCR_RST;

  logic              bd_clr;
  logic              rtcsel_reopen;
  logic              rtcsel_wr;
  rcc_pkg::rtc_src_e rtcsel_q;
  logic              css_seen;

  // domain clear, also in the cycle bdrst is written
  // so every field drops together with the write
  assign bd_clr = bdrst | (byte2_wren & nxt_bdrst);

  // ------------------------------
  // byte 2
  // ------------------------------
  // bdrst, plain rw
  always_ff @(posedge clk) begin
    if (rst) begin
      bdrst <= RV[rcc_pkg::BIT_BDRST];
    end else if (byte2_wren) begin
      bdrst <= nxt_bdrst;
    end
  end

  // ------------------------------
  // byte 1
  // ------------------------------
  // rtcen
  always_ff @(posedge clk) begin
    if (rst || bd_clr) begin
      rtcen <= RV[rcc_pkg::BIT_RTCEN];
    end else if (byte1_wren) begin
      rtcen <= nxt_rtcen;
    end
  end

  // rtcsel takes a write while none or reopened
  assign rtcsel_wr = byte1_wren & ((rtcsel == rcc_pkg::RTC_NONE) | rtcsel_reopen);

  // reopen flag armed by a css failure
  // consumed by the next accepted write
  always_ff @(posedge clk) begin
    if (rst || bd_clr) begin
      rtcsel_reopen <= 1'b0;
    end else if (lsecss_fail) begin
      rtcsel_reopen <= 1'b1;
    end else if (rtcsel_wr) begin
      rtcsel_reopen <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || bd_clr) begin
      rtcsel <= rcc_pkg::RTC_NONE;
    end else if (rtcsel_wr) begin
      rtcsel <= nxt_rtcsel;
    end
  end

  // ------------------------------
  // byte 0
  // ------------------------------
  // lsecsson set-only from software
  // failure clears it and wins over a set
  always_ff @(posedge clk) begin
    if (rst || bd_clr || lsecss_fail) begin
      lsecsson <= RV[rcc_pkg::BIT_LSECSSON];
    end else if (byte0_wren && nxt_lsecsson) begin
      lsecsson <= 1'b1;
    end
  end

  // lsecssd sticky until rst or bdrst
  always_ff @(posedge clk) begin
    if (rst || bd_clr) begin
      lsecssd <= RV[rcc_pkg::BIT_LSECSSD];
    end else if (lsecss_fail) begin
      lsecssd <= 1'b1;
    end
  end

  // plain rw fields of byte 0
  always_ff @(posedge clk) begin
    if (rst || bd_clr) begin
      lsedrv <= RV[rcc_pkg::LSB_LSEDRV +: 2];
      lsebyp <= RV[rcc_pkg::BIT_LSEBYP];
      lseon  <= RV[rcc_pkg::BIT_LSEON];
    end else if (byte0_wren) begin
      lsedrv <= nxt_lsedrv;
      lsebyp <= nxt_lsebyp;
      lseon  <= nxt_lseon;
    end
  end

  // ------------------------------
  // read-back assembly
  // ------------------------------
  always_comb begin
    cur_bdcr                                = '0;
    cur_bdcr[rcc_pkg::BIT_BDRST]            = bdrst;
    cur_bdcr[rcc_pkg::BIT_RTCEN]            = rtcen;
    cur_bdcr[rcc_pkg::LSB_RTCSEL +: 2]      = rtcsel;
    cur_bdcr[rcc_pkg::BIT_LSECSSD]          = lsecssd;
    cur_bdcr[rcc_pkg::BIT_LSECSSON]         = lsecsson;
    cur_bdcr[rcc_pkg::LSB_LSEDRV +: 2]      = lsedrv;
    cur_bdcr[rcc_pkg::BIT_LSEBYP]           = lsebyp;
    // lserdy comes live from the oscillator block
    cur_bdcr[rcc_pkg::BIT_LSERDY]           = lserdy;
    cur_bdcr[rcc_pkg::BIT_LSEON]            = lseon;
  end

  // ------------------------------
  // checks
  // ------------------------------
  // previous source, and a failure seen since its last change
  always_ff @(posedge clk) begin
    if (rst) begin
      rtcsel_q <= rcc_pkg::RTC_NONE;
      css_seen <= 1'b0;
    end else begin
      rtcsel_q <= rtcsel;
      if (lsecss_fail) begin
        css_seen <= 1'b1;
      end else if (rtcsel != rtcsel_q) begin
        css_seen <= 1'b0;
      end
    end
  end

  // a running source is never swapped without a css failure in between
  a_rtcsel_locked: assert property (
    @(posedge clk) disable iff (rst)
    (rtcsel_q != rcc_pkg::RTC_NONE && rtcsel != rcc_pkg::RTC_NONE &&
     rtcsel != rtcsel_q) |-> css_seen
  ) else $error("rtcsel changed without an lsecss_fail");

endmodule

`default_nettype wire

// File: src/rcc_vsw_top.sv
// ------------------------------
// bdcr slice top, single clk domain
// tick inputs are one-cycle pulses on clk
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module rcc_vsw_top #(
  parameter int LSE_STARTUP = 8,
  parameter int CSS_TIMEOUT = 32,
  parameter int HSE_DIV     = 4
) (
  input  wire                           clk,
  input  wire                           rst,
  // apb4
  input  wire  [rcc_pkg::ADDR_W-1:0]    paddr,
  input  wire                           psel,
  input  wire                           penable,
  input  wire                           pwrite,
  input  wire  [rcc_pkg::DATA_W-1:0]    pwdata,
  input  wire  [rcc_pkg::DATA_W/8-1:0]  pstrb,
  output logic [rcc_pkg::DATA_W-1:0]    prdata,
  output logic                          pslverr,
  // source ticks
  input  wire                           lse_tick,
  input  wire                           lsi_tick,
  input  wire                           hse_tick,
  // kernel tick and css event
  output logic                          rtc_tick,
  output logic                          lsecss_fail,
  // bdcr fields
  output logic                          bdrst,
  output logic                          rtcen,
  output rcc_pkg::rtc_src_e             rtcsel,
  output logic                          lsecssd,
  output logic                          lsecsson,
  output logic [1:0]                    lsedrv,
  output logic                          lsebyp,
  output logic                          lseon,
  output logic                          lserdy
);

  logic                        byte2_wren;
  logic                        byte1_wren;
  logic                        byte0_wren;
  logic                        nxt_bdrst;
  logic                        nxt_rtcen;
  rcc_pkg::rtc_src_e           nxt_rtcsel;
  logic                        nxt_lsecsson;
  logic [1:0]                  nxt_lsedrv;
  logic                        nxt_lsebyp;
  logic                        nxt_lseon;
  logic [rcc_pkg::DATA_W-1:0]  cur_bdcr;

  // bus side
  rcc_apb_slave u_apb_slave (
    .clk          (clk),
    .rst          (rst),
    .paddr        (paddr),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .pwdata       (pwdata),
    .pstrb        (pstrb),
    .prdata       (prdata),
    .pslverr      (pslverr),
    .byte2_wren   (byte2_wren),
    .byte1_wren   (byte1_wren),
    .byte0_wren   (byte0_wren),
    .nxt_bdrst    (nxt_bdrst),
    .nxt_rtcen    (nxt_rtcen),
    .nxt_rtcsel   (nxt_rtcsel),
    .nxt_lsecsson (nxt_lsecsson),
    .nxt_lsedrv   (nxt_lsedrv),
    .nxt_lsebyp   (nxt_lsebyp),
    .nxt_lseon    (nxt_lseon),
    .cur_bdcr     (cur_bdcr)
  );

  // register bank
  rcc_vsw_reg u_vsw_reg (
    .clk          (clk),
    .rst          (rst),
    .byte2_wren   (byte2_wren),
    .byte1_wren   (byte1_wren),
    .byte0_wren   (byte0_wren),
    .nxt_bdrst    (nxt_bdrst),
    .nxt_rtcen    (nxt_rtcen),
    .nxt_rtcsel   (nxt_rtcsel),
    .nxt_lsecsson (nxt_lsecsson),
    .nxt_lsedrv   (nxt_lsedrv),
    .nxt_lsebyp   (nxt_lsebyp),
    .nxt_lseon    (nxt_lseon),
    .lsecss_fail  (lsecss_fail),
    .lserdy       (lserdy),
    .bdrst        (bdrst),
    .rtcen        (rtcen),
    .rtcsel       (rtcsel),
    .lsecssd      (lsecssd),
    .lsecsson     (lsecsson),
    .lsedrv       (lsedrv),
    .lsebyp       (lsebyp),
    .lseon        (lseon),
    .cur_bdcr     (cur_bdcr)
  );

  // oscillator and rtc source
  rcc_lse_ctrl #(
    .LSE_STARTUP  (LSE_STARTUP),
    .CSS_TIMEOUT  (CSS_TIMEOUT),
    .HSE_DIV      (HSE_DIV)
  ) u_lse_ctrl (
    .clk          (clk),
    .rst          (rst),
    .lseon        (lseon),
    .lsebyp       (lsebyp),
    .lsecsson     (lsecsson),
    .rtcen        (rtcen),
    .rtcsel       (rtcsel),
    .lse_tick     (lse_tick),
    .lsi_tick     (lsi_tick),
    .hse_tick     (hse_tick),
    .lserdy       (lserdy),
    .lsecss_fail  (lsecss_fail),
    .rtc_tick     (rtc_tick)
  );

endmodule

`default_nettype wire

// File: tests/tb_rcc_tasks.svh
// ------------------------------
// apb, lfsr and wait helpers for the bdcr testbench
// included inside the testbench module, uses its signals
// apb tasks start and end on a falling edge
// ------------------------------
`ifndef TB_RCC_TASKS_SVH
`define TB_RCC_TASKS_SVH

  // galois lfsr, x^16 + x^14 + x^13 + x^11 + 1
  logic [15:0] lfsr_state = 16'd49375;

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v[k] = lfsr_bit();
    end
    return v;
  endfunction

  // ------------------------------
  // apb4 transfers
  // ------------------------------
  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic err);
    paddr   = addr;
    pwdata  = data;
    pstrb   = strb;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    // response is sampled just before the completing edge
    #(HALF - 1);
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pstrb   = 4'h0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                          output logic err);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #(HALF - 1);
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // idle cycles until the css pulse, bounded by limit
  task automatic wait_css_fail(input int limit, output int cycles);
    cycles = 0;
    while (!lsecss_fail) begin
      if (cycles >= limit) begin
        report_timeout("lsecss_fail");
      end
      step_cycle(1'b0, 1'b0, 1'b0);
      cycles++;
    end
  endtask

`endif

// File: tests/tb_rcc_vsw.sv
// ------------------------------
// testbench for the bdcr slice
// inputs change on the falling edge, outputs checked there too
// first failing check ends the run
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_rcc_vsw;

  localparam int HALF        = 5;
  localparam int LSE_STARTUP = 8;
  localparam int CSS_TIMEOUT = 32;
  localparam int HSE_DIV     = 4;

  // ------------------------------
  // expected field words
  // ------------------------------
  localparam logic [31:0] RW_MASK = (32'd1 << rcc_pkg::BIT_RTCEN) |
                                    (32'd3 << rcc_pkg::LSB_LSEDRV) |
                                    (32'd1 << rcc_pkg::BIT_LSEBYP) |
                                    (32'd1 << rcc_pkg::BIT_LSEON);
  localparam logic [31:0] BDRST   = 32'd1 << rcc_pkg::BIT_BDRST;
  localparam logic [31:0] RTCEN   = 32'd1 << rcc_pkg::BIT_RTCEN;
  localparam logic [31:0] CSSD    = 32'd1 << rcc_pkg::BIT_LSECSSD;
  localparam logic [31:0] CSSON   = 32'd1 << rcc_pkg::BIT_LSECSSON;
  localparam logic [31:0] LSEON   = 32'd1 << rcc_pkg::BIT_LSEON;
  localparam logic [31:0] SEL_LSI = 32'(rcc_pkg::RTC_LSI) << rcc_pkg::LSB_RTCSEL;
  localparam logic [31:0] SEL_HSE = 32'(rcc_pkg::RTC_HSE) << rcc_pkg::LSB_RTCSEL;

  logic              clk = 1'b0;
  logic              rst;
  logic [11:0]       paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [3:0]        pstrb;
  logic [31:0]       prdata;
  logic              pslverr;
  logic              lse_tick;
  logic              lsi_tick;
  logic              hse_tick;
  logic              rtc_tick;
  logic              lsecss_fail;
  logic              bdrst;
  logic              rtcen;
  rcc_pkg::rtc_src_e rtcsel;
  logic              lsecssd;
  logic              lsecsson;
  logic [1:0]        lsedrv;
  logic              lsebyp;
  logic              lseon;
  logic              lserdy;
  // rtc_tick pulses seen since last cleared
  int                rtc_count;

  rcc_vsw_top #(
    .LSE_STARTUP (LSE_STARTUP),
    .CSS_TIMEOUT (CSS_TIMEOUT),
    .HSE_DIV     (HSE_DIV)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .pstrb       (pstrb),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .lse_tick    (lse_tick),
    .lsi_tick    (lsi_tick),
    .hse_tick    (hse_tick),
    .rtc_tick    (rtc_tick),
    .lsecss_fail (lsecss_fail),
    .bdrst       (bdrst),
    .rtcen       (rtcen),
    .rtcsel      (rtcsel),
    .lsecssd     (lsecssd),
    .lsecsson    (lsecsson),
    .lsedrv      (lsedrv),
    .lsebyp      (lsebyp),
    .lseon       (lseon),
    .lserdy      (lserdy)
  );

  always #HALF clk = ~clk;

  // ------------------------------
  // error reporting
  // ------------------------------
  task automatic stop_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic fail_value(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    $display("** Error [%s]: expected 0x%08h, actual 0x%08h", name, exp, act);
    stop_run();
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    stop_run();
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp,
                          input logic [31:0] act);
    assert (act === exp) else fail_value(name, exp, act);
  endtask

  // one clk cycle with the given tick pattern, counts rtc_tick
  task automatic step_cycle(input logic lse, input logic lsi, input logic hse);
    lse_tick = lse;
    lsi_tick = lsi;
    hse_tick = hse;
    @(negedge clk);
    lse_tick = 1'b0;
    lsi_tick = 1'b0;
    hse_tick = 1'b0;
    if (rtc_tick) begin
      rtc_count++;
    end
  endtask

  `include "tb_rcc_tasks.svh"

  // n pulses of one source (0 lse, 1 lsi, 2 hse) with random gaps
  task automatic send_ticks(input int src, input int n);
    int k;
    int gap;
    for (k = 0; k < n; k++) begin
      gap = int'(rand_bits(2));
      repeat (gap) step_cycle(1'b0, 1'b0, 1'b0);
      step_cycle(src == 0, src == 1, src == 2);
    end
    step_cycle(1'b0, 1'b0, 1'b0);
    step_cycle(1'b0, 1'b0, 1'b0);
  endtask

  // ------------------------------
  // concurrent checks
  // ------------------------------
  a_css_drops_ready: assert property (
    @(posedge clk) disable iff (rst) lsecss_fail |-> !lserdy
  ) else fail_value("css_lserdy_drop", 0, 32'(lserdy));

  // sticky flag set and monitor disarmed after the pulse
  a_css_status: assert property (
    @(posedge clk) disable iff (rst) lsecss_fail |=> (lsecssd && !lsecsson)
  ) else fail_value("css_status_bits", 32'b10, 32'({lsecssd, lsecsson}));

  a_bdrst_fields: assert property (
    @(posedge clk) disable iff (rst)
    bdrst |-> ({rtcen, rtcsel, lsecssd, lsecsson, lsedrv, lsebyp, lseon} == '0)
  ) else fail_value("bdrst_fields", 0,
                    32'({rtcen, rtcsel, lsecssd, lsecsson, lsedrv, lsebyp, lseon}));

  a_bdrst_no_tick: assert property (
    @(posedge clk) disable iff (rst) bdrst |=> !rtc_tick
  ) else fail_value("bdrst_rtc_tick", 0, 32'(rtc_tick));

  a_slverr_access: assert property (
    @(posedge clk) disable iff (rst) pslverr |-> (psel && penable)
  ) else fail_value("slverr_phase", 32'b11, 32'({psel, penable}));

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] exp;
    logic [31:0] r;
    logic [3:0]  strb;
    logic        err;
    int          i;
    int          j;
    int          n;
    int          gap;
    int          cycles;
    rst       = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    pstrb     = '0;
    lse_tick  = 1'b0;
    lsi_tick  = 1'b0;
    hse_tick  = 1'b0;
    rtc_count = 0;
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // rw fields, expected word merged per strobe
    exp = '0;
    for (i = 0; i < 8; i++) begin
      data = rand_bits(32) & RW_MASK;
      r    = rand_bits(4);
      strb = r[3:0];
      apb_write(rcc_pkg::BDCR_ADDR, data, strb, err);
      for (j = 0; j < 4; j++) begin
        if (strb[j]) begin
          exp[8*j +: 8] = data[8*j +: 8];
        end
      end
      apb_read(rcc_pkg::BDCR_ADDR, rd, err);
      check_eq("rw_fields", exp, rd);
      check_eq("rw_slverr", 0, 32'(err));
      // field ports follow the same write
      check_eq("rw_rtcen", 32'(exp[rcc_pkg::BIT_RTCEN]), 32'(rtcen));
      check_eq("rw_lsedrv", 32'(exp[rcc_pkg::LSB_LSEDRV +: 2]), 32'(lsedrv));
      check_eq("rw_lsebyp", 32'(exp[rcc_pkg::BIT_LSEBYP]), 32'(lsebyp));
      check_eq("rw_lseon", 32'(exp[rcc_pkg::BIT_LSEON]), 32'(lseon));
    end
    apb_read(12'h004, rd, err);
    check_eq("unmapped_read", 1, 32'(err));
    // unmapped write must not touch bdcr
    apb_write(12'h008, 32'hFFFF_FFFF, 4'hF, err);
    check_eq("unmapped_write", 1, 32'(err));
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("unmapped_no_effect", exp, rd);
    apb_write(rcc_pkg::BDCR_ADDR, 32'h0, 4'hF, err);

    // rtcsel write-once
    apb_write(rcc_pkg::BDCR_ADDR, SEL_LSI, 4'b0010, err);
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("rtcsel_first", SEL_LSI, rd);
    apb_write(rcc_pkg::BDCR_ADDR, SEL_HSE, 4'b0010, err);
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("rtcsel_locked", SEL_LSI, rd);
    check_eq("rtcsel_out", 32'(rcc_pkg::RTC_LSI), 32'(rtcsel));

    // lsecsson set-only
    apb_write(rcc_pkg::BDCR_ADDR, CSSON, 4'b0001, err);
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("csson_set", SEL_LSI | CSSON, rd);
    apb_write(rcc_pkg::BDCR_ADDR, 32'h0, 4'b0001, err);
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("csson_sticky", SEL_LSI | CSSON, rd);
    check_eq("csson_out", 1, 32'(lsecsson));

    // lserdy one cycle after the last startup tick
    apb_write(rcc_pkg::BDCR_ADDR, CSSON | LSEON, 4'b0001, err);
    for (i = 1; i <= LSE_STARTUP; i++) begin
      gap = int'(rand_bits(2));
      for (j = 0; j < gap; j++) begin
        step_cycle(1'b0, 1'b0, 1'b0);
        check_eq("lserdy_early", 0, 32'(lserdy));
      end
      step_cycle(1'b1, 1'b0, 1'b0);
      check_eq("lserdy_rise", (i == LSE_STARTUP) ? 1 : 0, 32'(lserdy));
    end

    // lse stops right after ready
    wait_css_fail(4 * CSS_TIMEOUT, cycles);
    check_eq("css_timeout", CSS_TIMEOUT, cycles);
    check_eq("css_lserdy", 0, 32'(lserdy));
    step_cycle(1'b0, 1'b0, 1'b0);
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("css_status", SEL_LSI | CSSD | LSEON, rd);
    apb_write(rcc_pkg::BDCR_ADDR, SEL_HSE, 4'b0010, err);
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("rtcsel_reopen", SEL_HSE | CSSD | LSEON, rd);

    // rtc from divided hse
    apb_write(rcc_pkg::BDCR_ADDR, RTCEN | SEL_HSE, 4'b0010, err);
    rtc_count = 0;
    n = 3 * HSE_DIV + int'(rand_bits(2));
    send_ticks(2, n);
    check_eq("rtc_hse", n / HSE_DIV, rtc_count);

    // bdrst to unlock rtcsel, then rtc from lsi
    apb_write(rcc_pkg::BDCR_ADDR, BDRST, 4'b0100, err);
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("bdrst_clear", BDRST, rd);
    check_eq("bdrst_out", 1, 32'(bdrst));
    apb_write(rcc_pkg::BDCR_ADDR, 32'h0, 4'b0100, err);
    apb_write(rcc_pkg::BDCR_ADDR, RTCEN | SEL_LSI, 4'b0010, err);
    rtc_count = 0;
    n = 5 + int'(rand_bits(3));
    send_ticks(1, n);
    check_eq("rtc_lsi", n, rtc_count);

    // no kernel tick while the domain is held in reset
    apb_write(rcc_pkg::BDCR_ADDR, BDRST, 4'b0100, err);
    rtc_count = 0;
    send_ticks(1, 6);
    send_ticks(2, 2 * HSE_DIV);
    check_eq("rtc_after_bdrst", 0, rtc_count);
    apb_read(rcc_pkg::BDCR_ADDR, rd, err);
    check_eq("bdrst_readback", BDRST, rd);

    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tests
src/rcc_pkg.sv
src/rcc_apb_slave.sv
src/rcc_vsw_reg.sv
src/rcc_lse_ctrl.sv
src/rcc_vsw_top.sv
tests/tb_rcc_vsw.sv
